// File: hdl/stream_defines.svh
// Stream frame engine constants.
// FIFO sizes, frame opcodes and result status codes shared by the
// RTL and the testbench.

`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// Input byte FIFO holds 2**4 - 1 beats.
`define IN_FIFO_AW 4

// Output result FIFO holds 2**2 - 1 words.
`define OUT_FIFO_AW 2

// Header opcodes.
`define OP_SUM 8'd0
`define OP_XOR 8'd1
`define OP_CNT 8'd2

// Result status codes. A bad beat wins over an unknown opcode.
`define ST_OK      8'd0
`define ST_BAD     8'd1
`define ST_UNKNOWN 8'd2

`endif

// File: hdl/stream_pkg.sv
// Stream frame engine types.
// Input beat, decoded payload beat, result record and output word.

`default_nettype none

package stream_pkg;

    // One byte beat of the input stream.
    typedef struct packed {
        logic [7:0] data;     // Byte payload.
        logic       user;     // Bad beat marker (tuser).
        logic       last;     // End of frame (tlast).
    } byte_beat_t;

    // One payload beat after header removal.
    typedef struct packed {
        logic [7:0] op;       // Opcode from the frame header.
        logic [7:0] data;     // Payload byte.
        logic       bad;      // Bad beat, or the header was bad.
        logic       unknown;  // Header opcode is not recognized.
        logic       last;     // Final beat of the frame.
        logic       empty;    // Header-only frame, data not valid.
    } dec_beat_t;

    // Per-frame result record.
    typedef struct packed {
        logic [7:0]  op;      // Opcode of the frame.
        logic [7:0]  status;  // Ok, bad or unknown.
        logic [15:0] value;   // Zero unless status is ok.
    } result_t;

    // Single-beat output word.
    typedef struct packed {
        logic [31:0] data;    // Packed op, status and value.
        logic        last;    // Always set.
    } result_word_t;

endpackage

`default_nettype wire

// File: hdl/axis_fifo.sv
// Valid/ready FIFO.
// Circular buffer with an occupancy counter and a registered output
// stage; the payload is any packed type. One slot is left unused.

`timescale 1ns/100ps
`default_nettype none

module axis_fifo #(
    parameter int  ADDR_WIDTH = 4,            // Log2 of the buffer size.
    parameter type payload_t  = logic [7:0]   // Beat carried through.
) (
    input  wire           clk,
    input  wire           rst,

    input  wire payload_t in_data,            // Write side.
    input  wire           in_valid,
    output logic          in_ready,

    output payload_t      out_data,           // Read side, registered.
    output logic          out_valid,
    input  wire           out_ready
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam logic [ADDR_WIDTH-1:0] MAX_COUNT = ADDR_WIDTH'(DEPTH - 1);

    payload_t mem [DEPTH];                    // Beat storage.

    logic [ADDR_WIDTH-1:0] wr_ptr;            // Next slot to write.
    logic [ADDR_WIDTH-1:0] rd_ptr;            // Next slot to read.
    logic [ADDR_WIDTH-1:0] count;             // Beats held in mem.

    logic full;
    logic empty;
    logic write;
    logic read;

    assign full  = (count == MAX_COUNT);
    assign empty = (count == '0);

    assign write = in_valid && !full;
    // Refill the output register when it is empty or being drained.
    assign read  = (out_ready || !out_valid) && !empty;

    assign in_ready = !full;

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= in_data;           // Storage has no reset.
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            out_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;      // Wraps with the buffer.
            end
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (write && !read) begin
                count <= count + 1'b1;
            end else if (read && !write) begin
                count <= count - 1'b1;
            end
            if (out_ready || !out_valid) begin
                out_valid <= !empty;          // Valid follows the refill.
            end
        end
    end

    // A beat refused while full is held by its source, or it is lost.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (in_valid && full) |=> (in_valid && $stable(in_data)));

    // A stalled output beat holds still until it is taken.
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

// File: hdl/frame_decode.sv
// Frame decoder.
// Strips the opcode header from each frame and forwards payload beats
// tagged with the opcode, the unknown flag and a bad flag. A
// header-only frame becomes one beat with empty set.

`timescale 1ns/100ps
`default_nettype none

`include "stream_defines.svh"

module frame_decode (
    input  wire                     clk,
    input  wire                     rst,

    input  wire stream_pkg::byte_beat_t in_beat,
    input  wire                     in_valid,
    output logic                    in_ready,

    output stream_pkg::dec_beat_t   dec,
    output logic                    dec_valid,
    input  wire                     dec_ready
);

    logic       in_payload;    // Low while waiting for a header beat.
    logic [7:0] op_q;          // Opcode of the current frame.
    logic       unknown_q;     // Current opcode is not recognized.
    logic       hdr_bad_q;     // Header beat carried tuser.
    logic       hdr_unknown;   // Unknown opcode on the incoming header.
    logic       take;          // Input beat transfers this cycle.

    assign hdr_unknown = !(in_beat.data inside {`OP_SUM, `OP_XOR, `OP_CNT});
    assign take        = in_valid && in_ready;

    always_comb begin
        if (in_payload) begin
            in_ready    = dec_ready;          // Straight pass-through.
            dec_valid   = in_valid;
            dec.op      = op_q;
            dec.data    = in_beat.data;
            dec.bad     = in_beat.user || hdr_bad_q;
            dec.unknown = unknown_q;
            dec.last    = in_beat.last;
            dec.empty   = 1'b0;
        end else begin
            // A header is swallowed unless it also closes the frame.
            in_ready    = !in_beat.last || dec_ready;
            dec_valid   = in_valid && in_beat.last;
            dec.op      = in_beat.data;
            dec.data    = 8'd0;
            dec.bad     = in_beat.user;
            dec.unknown = hdr_unknown;
            dec.last    = 1'b1;
            dec.empty   = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_payload <= 1'b0;
            unknown_q  <= 1'b0;
            hdr_bad_q  <= 1'b0;
        end else if (take) begin
            if (!in_payload && !in_beat.last) begin
                in_payload <= 1'b1;           // Header done, payload follows.
                unknown_q  <= hdr_unknown;
                hdr_bad_q  <= in_beat.user;
            end else if (in_payload && in_beat.last) begin
                in_payload <= 1'b0;           // Back to header for next frame.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !in_payload) begin
            op_q <= in_beat.data;
        end
    end

    // Every closing beat sends the decoder back to header state.
    a_last_to_hdr: assert property (@(posedge clk) disable iff (rst)
        (take && in_beat.last) |=> !in_payload);

endmodule

`default_nettype wire

// File: hdl/frame_execute.sv
// Frame executor.
// Accumulates sum, XOR and count over a frame's payload beats and
// emits one result record when the last beat is accepted.

`timescale 1ns/100ps
`default_nettype none

`include "stream_defines.svh"

module frame_execute (
    input  wire                        clk,
    input  wire                        rst,

    input  wire stream_pkg::dec_beat_t dec,
    input  wire                        dec_valid,
    output logic                       dec_ready,

    output stream_pkg::result_t        res,
    output logic                       res_valid,
    input  wire                        res_ready
);

    logic [15:0] sum_q;          // Running byte sum, mod 2^16.
    logic [7:0]  xor_q;          // Running byte XOR.
    logic [15:0] cnt_q;          // Payload bytes seen.
    logic        bad_q;          // Sticky bad beat flag.

    logic [15:0] sum_next;
    logic [7:0]  xor_next;
    logic [15:0] cnt_next;
    logic        bad_next;
    logic [7:0]  status_next;
    logic [15:0] value_sel;      // Value picked by opcode.
    logic [15:0] value_next;
    logic        accept;

    // Stall input only while a result waits.
    assign dec_ready = !res_valid || res_ready;
    assign accept    = dec_valid && dec_ready;

    always_comb begin
        sum_next = sum_q + (dec.empty ? 16'd0 : {8'd0, dec.data});
        xor_next = xor_q ^ (dec.empty ? 8'd0 : dec.data);
        cnt_next = cnt_q + (dec.empty ? 16'd0 : 16'd1);
        bad_next = bad_q || dec.bad;

        if (bad_next) begin
            status_next = `ST_BAD;            // Bad wins over unknown.
        end else if (dec.unknown) begin
            status_next = `ST_UNKNOWN;
        end else begin
            status_next = `ST_OK;
        end

        case (dec.op)
            `OP_SUM: value_sel = sum_next;
            `OP_XOR: value_sel = {8'd0, xor_next};
            `OP_CNT: value_sel = cnt_next;
            default: value_sel = 16'd0;
        endcase

        value_next = (status_next == `ST_OK) ? value_sel : 16'd0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum_q     <= 16'd0;
            xor_q     <= 8'd0;
            cnt_q     <= 16'd0;
            bad_q     <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;
            end
            if (accept) begin
                if (dec.last) begin
                    sum_q     <= 16'd0;       // Fresh frame next.
                    xor_q     <= 8'd0;
                    cnt_q     <= 16'd0;
                    bad_q     <= 1'b0;
                    res_valid <= 1'b1;
                end else begin
                    sum_q <= sum_next;
                    xor_q <= xor_next;
                    cnt_q <= cnt_next;
                    bad_q <= bad_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && dec.last) begin
            res.op     <= dec.op;
            res.status <= status_next;
            res.value  <= value_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_result.sv
// Result stage.
// Packs a result record into the 32-bit output word with last set and
// holds it in a register while the output FIFO applies back-pressure.

`timescale 1ns/100ps
`default_nettype none

`include "stream_defines.svh"

module frame_result (
    input  wire                      clk,
    input  wire                      rst,

    input  wire stream_pkg::result_t res,
    input  wire                      res_valid,
    output logic                     res_ready,

    output stream_pkg::result_word_t word,
    output logic                     word_valid,
    input  wire                      word_ready
);

    logic take;                       // Result transfers this cycle.

    // Register refills on the same edge it drains.
    assign res_ready = !word_valid || word_ready;
    assign take      = res_valid && res_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_valid <= 1'b0;
        end else if (take) begin
            word_valid <= 1'b1;
        end else if (word_ready) begin
            word_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            word.data <= {res.op, res.status, res.value};   // Op high, value low.
            word.last <= 1'b1;        // One beat per result.
        end
    end

    // Execute zeroes the value of any failed frame.
    a_value_zero: assert property (@(posedge clk) disable iff (rst)
        (word_valid && (word.data[23:16] != `ST_OK)) |-> (word.data[15:0] == 16'd0));

endmodule

`default_nettype wire

// File: hdl/frame_engine_top.sv
// Stream frame engine.
// Byte frames in, one 32-bit result word per frame out. Chain is
// input FIFO, decode, execute, result register, output FIFO; every
// link is valid/ready so back-pressure stalls the whole path.

`timescale 1ns/100ps
`default_nettype none

`include "stream_defines.svh"

module frame_engine_top (
    input  wire                          clk,
    input  wire                          rst,

    input  wire stream_pkg::byte_beat_t  in_beat,
    input  wire                          in_valid,
    output logic                         in_ready,

    output stream_pkg::result_word_t     out_beat,
    output logic                         out_valid,
    input  wire                          out_ready
);

    import stream_pkg::*;

    byte_beat_t   fifo_beat;          // Input FIFO to decode.
    logic         fifo_valid;
    logic         fifo_ready;

    dec_beat_t    dec;                // Decode to execute.
    logic         dec_valid;
    logic         dec_ready;

    result_t      res;                // Execute to result stage.
    logic         res_valid;
    logic         res_ready;

    result_word_t word;               // Result stage to output FIFO.
    logic         word_valid;
    logic         word_ready;

    axis_fifo #(
        .ADDR_WIDTH (`IN_FIFO_AW),
        .payload_t  (byte_beat_t)
    ) u_in_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (fifo_beat),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    frame_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_beat),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .dec       (dec),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready)
    );

    frame_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    frame_result u_result (
        .clk        (clk),
        .rst        (rst),
        .res        (res),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready)
    );

    axis_fifo #(
        .ADDR_WIDTH (`OUT_FIFO_AW),
        .payload_t  (result_word_t)
    ) u_out_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (word),
        .in_valid  (word_valid),
        .in_ready  (word_ready),
        .out_data  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: tests/frame_engine_tb.sv
// Stream frame engine testbench.
// Sends random opcode frames with random payloads, bad beats and input
// gaps, stalls the output at random, and compares every result word
// against a reference model in frame order.

`timescale 1ns/100ps
`default_nettype none

`include "stream_defines.svh"

module frame_engine_tb;

    import stream_pkg::*;

    localparam int          NUM_FRAMES  = 200;
    localparam int          MAX_PAYLOAD = 20;
    localparam int          MAX_BEATS   = MAX_PAYLOAD + 2;  // Header, payload, one spare.
    localparam int          CLK_NS      = 8;
    localparam int          TIMEOUT_NS  = NUM_FRAMES * MAX_BEATS * 4 * CLK_NS + 20000;
    localparam logic [31:0] SEED        = 32'h1e3f_00de;

    logic         clk;
    logic         rst;
    byte_beat_t   in_beat;
    logic         in_valid;
    logic         in_ready;
    result_word_t out_beat;
    logic         out_valid;
    logic         out_ready;

    logic [31:0]  exp_q [$];     // Expected words, oldest first.
    int           errors;
    int           words_seen;    // Output transfers so far.

    frame_engine_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // Reference model of one frame result.
    function automatic logic [31:0] expected_word(input logic [7:0] op,
                                                  input logic [7:0] payload [MAX_PAYLOAD],
                                                  input int len,
                                                  input logic bad);
        logic [15:0] sum;
        logic [7:0]  parity;
        logic [15:0] cnt;
        logic [7:0]  status;
        logic [15:0] value;
        sum    = 16'd0;
        parity = 8'd0;
        cnt    = 16'd0;
        for (int i = 0; i < len; i++) begin
            sum    = sum + {8'd0, payload[i]};   // Wraps at 2^16.
            parity = parity ^ payload[i];
            cnt    = cnt + 16'd1;
        end
        if (bad) begin
            status = `ST_BAD;                    // Bad beat beats unknown opcode.
        end else if (op != `OP_SUM && op != `OP_XOR && op != `OP_CNT) begin
            status = `ST_UNKNOWN;
        end else begin
            status = `ST_OK;
        end
        value = 16'd0;
        if (status == `ST_OK) begin
            if (op == `OP_SUM) begin
                value = sum;
            end else if (op == `OP_XOR) begin
                value = {8'd0, parity};
            end else begin
                value = cnt;
            end
        end
        return {op, status, value};
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Hard stop if results never show up.
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns: only %0d of %0d results arrived",
                 TIMEOUT_NS, words_seen, NUM_FRAMES);
        $display("TEST FAILED");
        $finish;
    end

    // One input beat, called on a falling edge; returns on the falling edge after transfer.
    task automatic send_beat(input logic [7:0] data, input logic user, input logic last);
        logic accepted;
        if ($urandom_range(0, 3) == 0) begin
            in_valid = 1'b0;                     // Random idle cycle.
            @(negedge clk);
        end
        in_beat.data = data;
        in_beat.user = user;
        in_beat.last = last;
        in_valid     = 1'b1;
        accepted     = 1'b0;
        while (!accepted) begin
            accepted = in_ready;                 // Steady until the next rising edge.
            @(negedge clk);
        end
    endtask

    // Builds one random frame, queues its expected word, then sends it.
    task automatic send_frame();
        logic [7:0] op;
        logic [7:0] payload [MAX_PAYLOAD];
        logic       user [MAX_PAYLOAD + 1];
        logic       inject;
        logic       any_bad;
        int         len;
        int         sel;
        sel = int'($urandom_range(0, 4));
        if (sel < 3) begin
            op = 8'(sel);                        // Known opcode.
        end else begin
            op = 8'($urandom_range(3, 255));     // Unknown opcode.
        end
        if ($urandom_range(0, 7) == 0) begin
            len = 0;                             // Header-only frame.
        end else begin
            len = int'($urandom_range(0, MAX_PAYLOAD));
        end
        inject  = ($urandom_range(0, 3) == 0);
        any_bad = 1'b0;
        for (int i = 0; i <= len; i++) begin
            user[i] = inject && ($urandom_range(0, 3) == 0);  // Index 0 is the header.
            any_bad = any_bad || user[i];
        end
        for (int i = 0; i < MAX_PAYLOAD; i++) begin
            payload[i] = (i < len) ? 8'($urandom_range(0, 255)) : 8'd0;
        end
        exp_q.push_back(expected_word(op, payload, len, any_bad));
        send_beat(op, user[0], len == 0);
        for (int i = 0; i < len; i++) begin
            send_beat(payload[i], user[i + 1], i == len - 1);
        end
    endtask

    // Output stalls and result compare, both on the falling edge.
    initial begin
        int          stall;
        logic [31:0] expected;
        out_ready = 1'b0;
        stall     = 0;
        forever begin
            @(negedge clk);
            if (stall > 0) begin
                stall--;
            end else if ($urandom_range(0, 15) == 0) begin
                stall = int'($urandom_range(1, 120));  // Long enough to fill the input FIFO.
            end
            out_ready = (stall == 0);
            if (!rst && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output word %h at %0t ns arrived with no frame pending",
                             out_beat.data, $time);
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    if (out_beat.data !== expected) begin
                        $display("Error at %0t ns: result word %h, expected %h",
                                 $time, out_beat.data, expected);
                        errors++;
                    end
                    if (out_beat.last !== 1'b1) begin
                        $display("Error at %0t ns: output beat without last", $time);
                        errors++;
                    end
                end
                words_seen++;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_beat    = '0;
        errors     = 0;
        words_seen = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            $display("Error at %0t ns: wrong handshake state after reset", $time);
            errors++;
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
        end
        in_valid = 1'b0;
        wait (words_seen >= NUM_FRAMES);
        repeat (50) @(negedge clk);              // Room for any stray extra word.
        if (exp_q.size() != 0 || words_seen != NUM_FRAMES) begin
            $display("Result count mismatch: %0d words seen for %0d frames",
                     words_seen, NUM_FRAMES);
            errors++;
        end
        $display("Frames sent %0d, words checked %0d, errors %0d",
                 NUM_FRAMES, words_seen, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/axis_fifo.sv
hdl/frame_decode.sv
hdl/frame_execute.sv
hdl/frame_result.sv
hdl/frame_engine_top.sv
tests/frame_engine_tb.sv

// File: run.sh
#!/bin/sh
# Builds the frame engine testbench with Verilator and runs it.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f list.f --top-module frame_engine_tb -o frame_engine_sim \
    && ./obj_dir/frame_engine_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error"

cat sim.log 2>/dev/null
grep -q "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
